/* Makefile */
# Verilator build and run for the l2 cache testbench

VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FILELIST  ?= l2_cache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* l2_cache.f */
+incdir+source
source/l2_cache_pkg.sv
source/set_store.sv
source/hit_access.sv
source/line_engine.sv
source/l2_cache.sv
verification/l2_cache_asserts.sv
verification/l2_cache_tb.sv

/* source/hit_access.sv */
////////////////////////////////////////////////////////////
// hit stage doing tag match, word select, write merge and lru order
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "l2_cache_macros.svh"

module hit_access (
    input  wire l2_cache_pkg::proc_req_t  req,
    input  wire l2_cache_pkg::cache_row_t row,
    input  wire l2_cache_pkg::lru_order_t order,
    output l2_cache_pkg::word_t           rdata,
    output logic                          hit,
    output logic                          miss,
    output l2_cache_pkg::way_idx_t        victim,
    output l2_cache_pkg::row_write_t      row_wr,
    output l2_cache_pkg::lru_write_t      lru_wr
);

    import l2_cache_pkg::*;

    decoded_addr_t             req_addr;
    logic                      req_valid;
    logic [`L2_ASSOC-1:0]      way_match;
    way_idx_t                  hit_way;
    way_idx_t [`L2_ASSOC-1:0]  list_in;     // [0] is the victim end
    way_idx_t [`L2_ASSOC-1:0]  list_out;
    logic                      shift;

    assign req_addr  = req.addr;
    assign req_valid = req.ren | req.wen;

    ////////////////////////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////////////////////////
    always_comb begin
        way_match = '0;
        hit_way   = '0;
        for (int i = 0; i < `L2_ASSOC; i++) begin
            if (row.frames[i].valid && row.frames[i].tag == req_addr.tag) begin
                way_match[i] = 1'b1;
                hit_way      = way_idx_t'(i);  // tags are unique within a set
            end
        end
    end

    assign hit    = req_valid && (|way_match);
    assign miss   = req_valid && !(|way_match);
    assign victim = order.victim;           // lru end of the list

    assign rdata = row.frames[hit_way].data[req_addr.block];

    ////////////////////////////////////////////////////////////
    // write-hit merge
    ////////////////////////////////////////////////////////////
    always_comb begin
        row_wr.en  = hit && req.wen;
        row_wr.row = row;
        row_wr.row.frames[hit_way].data[req_addr.block] = req.wdata;
        row_wr.row.frames[hit_way].dirty                = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // lru update
    ////////////////////////////////////////////////////////////
    assign list_in = {order.newest, order.older, order.next_victim, order.victim};

    // hit way moves to newest and the ones behind it slide down one
    always_comb begin
        list_out = list_in;
        shift    = 1'b0;
        for (int k = 0; k < `L2_ASSOC - 1; k++) begin
            if (list_in[k] == hit_way) begin
                shift = 1'b1;               // found the accessed way
            end
            if (shift) begin
                list_out[k] = list_in[k+1];
            end
        end
        list_out[`L2_ASSOC-1] = hit_way;
    end

    always_comb begin
        lru_wr.en                = hit;     // only a completing access reorders
        lru_wr.order.victim      = list_out[0];
        lru_wr.order.next_victim = list_out[1];
        lru_wr.order.older       = list_out[2];
        lru_wr.order.newest      = list_out[3];
    end

endmodule

`default_nettype wire

/* source/l2_cache.sv */
////////////////////////////////////////////////////////////
// top level of the 4-way write-back l2 cache with true lru
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "l2_cache_macros.svh"

module l2_cache (
    input  wire logic                    CLK,
    input  wire logic                    nRST,
    input  wire l2_cache_pkg::proc_req_t proc_req,
    output l2_cache_pkg::proc_rsp_t      proc_rsp,
    output l2_cache_pkg::mem_req_t       mem_req,
    input  wire l2_cache_pkg::mem_rsp_t  mem_rsp
);

    import l2_cache_pkg::*;

    localparam lru_order_t LRU_INIT = '{victim: 2'd0, next_victim: 2'd1, older: 2'd2, newest: 2'd3};

    decoded_addr_t req_addr;
    cache_row_t    row;             // selected set, all ways
    lru_order_t    order;           // selected set's lru list
    word_t         hit_rdata;
    logic          hit;
    logic          miss;
    way_idx_t      victim;
    row_write_t    hit_row_wr;      // write hit into engine
    row_write_t    eng_row_wr;      // engine into frame store
    lru_write_t    lru_wr;

    assign req_addr = proc_req.addr;

    ////////////////////////////////////////////////////////////
    // stores
    ////////////////////////////////////////////////////////////
    set_store #(.entry_t(cache_row_t), .n_entries(`L2_SETS), .reset_entry('0)) frame_store (
        .CLK(CLK), .nRST(nRST),
        .rd_index(req_addr.set_idx), .rd_entry(row),
        .wr_en(eng_row_wr.en), .wr_index(req_addr.set_idx), .wr_entry(eng_row_wr.row)
    );

    set_store #(.entry_t(lru_order_t), .n_entries(`L2_SETS), .reset_entry(LRU_INIT)) lru_store (
        .CLK(CLK), .nRST(nRST),
        .rd_index(req_addr.set_idx), .rd_entry(order),
        .wr_en(lru_wr.en), .wr_index(req_addr.set_idx), .wr_entry(lru_wr.order)
    );

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////
    hit_access hit0 (
        .req(proc_req), .row(row), .order(order),
        .rdata(hit_rdata), .hit(hit), .miss(miss), .victim(victim),
        .row_wr(hit_row_wr), .lru_wr(lru_wr)
    );

    line_engine eng0 (
        .CLK(CLK), .nRST(nRST),
        .req(proc_req), .miss(miss), .victim(victim), .row(row), .hit_wr(hit_row_wr),
        .row_wr(eng_row_wr), .mem_req(mem_req), .mem_rsp(mem_rsp), .busy(proc_rsp.busy)
    );

    assign proc_rsp.rdata = hit ? hit_rdata : '0;  // quiet bus unless completing

endmodule

`default_nettype wire

/* source/l2_cache_macros.svh */
////////////////////////////////////////////////////////////
// l2 cache geometry macros for ways, sets, line size and field widths
////////////////////////////////////////////////////////////
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// data path
`define L2_WORD_W       32  // bits per word and per address

// organisation
`define L2_ASSOC        4   // ways per set
`define L2_SETS         4   // sets in the cache
`define L2_BLOCK_WORDS  4   // words per line

// index widths
`define L2_WAY_BITS     2   // log2 of assoc
`define L2_SET_BITS     2   // log2 of sets
`define L2_BLOCK_BITS   2   // log2 of block words

// what is left of the address after set, word and byte
`define L2_TAG_BITS     (`L2_WORD_W - `L2_SET_BITS - `L2_BLOCK_BITS - 2)

`endif

/* source/l2_cache_pkg.sv */
////////////////////////////////////////////////////////////
// shared l2 cache types for address split, frames, lru and buses
////////////////////////////////////////////////////////////
`default_nettype none
`include "l2_cache_macros.svh"

package l2_cache_pkg;

    typedef logic [`L2_WORD_W-1:0]   word_t;     // data word or byte addr
    typedef logic [`L2_WAY_BITS-1:0] way_idx_t;  // way number

    typedef struct packed {
        logic [`L2_TAG_BITS-1:0]   tag;
        logic [`L2_SET_BITS-1:0]   set_idx;
        logic [`L2_BLOCK_BITS-1:0] block;       // word inside the line
        logic [1:0]                byte_off;
    } decoded_addr_t;

    typedef struct packed {
        logic                            valid;
        logic                            dirty;
        logic [`L2_TAG_BITS-1:0]         tag;
        word_t [`L2_BLOCK_WORDS-1:0]     data;
    } cache_frame_t;

    typedef struct packed {
        cache_frame_t [`L2_ASSOC-1:0] frames;   // all ways of one set
    } cache_row_t;

    // least recent first
    typedef struct packed {
        way_idx_t victim;
        way_idx_t next_victim;
        way_idx_t older;
        way_idx_t newest;
    } lru_order_t;

    typedef struct packed {
        word_t addr;
        logic  ren;
        logic  wen;
        word_t wdata;
    } proc_req_t;

    typedef struct packed {
        word_t rdata;
        logic  busy;
    } proc_rsp_t;

    typedef struct packed {
        word_t addr;
        logic  ren;
        logic  wen;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
        logic  busy;
    } mem_rsp_t;

    typedef struct packed {
        logic       en;
        cache_row_t row;
    } row_write_t;

    typedef struct packed {
        logic       en;
        lru_order_t order;
    } lru_write_t;

endpackage

`default_nettype wire

/* source/line_engine.sv */
////////////////////////////////////////////////////////////
// line engine for dirty write-back, line fetch and frame writes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "l2_cache_macros.svh"

module line_engine (
    input  wire logic                     CLK,
    input  wire logic                     nRST,
    input  wire l2_cache_pkg::proc_req_t  req,
    input  wire logic                     miss,
    input  wire l2_cache_pkg::way_idx_t   victim,
    input  wire l2_cache_pkg::cache_row_t row,
    input  wire l2_cache_pkg::row_write_t hit_wr,
    output l2_cache_pkg::row_write_t      row_wr,
    output l2_cache_pkg::mem_req_t        mem_req,
    input  wire l2_cache_pkg::mem_rsp_t   mem_rsp,
    output logic                          busy
);

    import l2_cache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WB,
        FETCH
    } state_t;

    localparam logic [`L2_BLOCK_BITS-1:0] LAST_WORD = `L2_BLOCK_BITS'(`L2_BLOCK_WORDS - 1);

    state_t                    state, next_state;
    logic [`L2_BLOCK_BITS-1:0] word_cnt, next_word_cnt;
    decoded_addr_t             req_addr;
    cache_frame_t              vframe;      // frame being replaced
    logic                      word_done;
    logic                      last_done;

    assign req_addr  = req.addr;
    assign vframe    = row.frames[victim];
    assign word_done = (state != IDLE) && !mem_rsp.busy;    // memory took the word
    assign last_done = word_done && (word_cnt == LAST_WORD);

    ////////////////////////////////////////////////////////////
    // state and word counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    next_state = vframe.dirty ? WB : FETCH;     // save victim first
                end
            end
            WB: begin
                if (last_done) begin
                    next_state = FETCH;
                end
            end
            FETCH: begin
                if (last_done) begin
                    next_state = IDLE;      // access retries as a hit
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        next_word_cnt = word_cnt;
        if (last_done) begin
            next_word_cnt = '0;             // ready for next phase
        end else if (word_done) begin
            next_word_cnt = word_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory bus
    ////////////////////////////////////////////////////////////
    always_comb begin
        mem_req = '0;
        case (state)
            WB: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = {vframe.tag, req_addr.set_idx, word_cnt, 2'b00};  // old line
                mem_req.wdata = vframe.data[word_cnt];
            end
            FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req_addr.tag, req_addr.set_idx, word_cnt, 2'b00}; // new line
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // frame row writes
    ////////////////////////////////////////////////////////////
    always_comb begin
        row_wr.en  = 1'b0;
        row_wr.row = row;
        case (state)
            IDLE: row_wr = hit_wr;          // pass write hits through
            WB: begin
                if (last_done) begin
                    row_wr.en                       = 1'b1;
                    row_wr.row.frames[victim].dirty = 1'b0;     // memory is current
                end
            end
            FETCH: begin
                if (word_done) begin
                    row_wr.en = 1'b1;
                    row_wr.row.frames[victim].data[word_cnt] = mem_rsp.rdata;
                    if (last_done) begin
                        row_wr.row.frames[victim].valid = 1'b1;
                        row_wr.row.frames[victim].dirty = 1'b0;
                        row_wr.row.frames[victim].tag   = req_addr.tag;
                    end
                end
            end
            default: ;
        endcase
    end

    assign busy = miss || (state != IDLE);  // low only on a hit or no request

endmodule

`default_nettype wire

/* source/set_store.sv */
////////////////////////////////////////////////////////////
// set store with one register entry per set and async read
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "l2_cache_macros.svh"

module set_store #(
    parameter type    entry_t     = logic [7:0],
    parameter int     n_entries   = `L2_SETS,
    parameter entry_t reset_entry = '0            // image loaded into every set
) (
    input  wire logic                    CLK,
    input  wire logic                    nRST,
    input  wire logic [`L2_SET_BITS-1:0] rd_index,
    output entry_t                       rd_entry,
    input  wire logic                    wr_en,
    input  wire logic [`L2_SET_BITS-1:0] wr_index,
    input  wire entry_t                  wr_entry
);

    entry_t entries [n_entries];    // one row per set

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < n_entries; i++) begin
                entries[i] <= reset_entry;      // known image per set
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;      // single writer port
        end
    end

    assign rd_entry = entries[rd_index];        // same-cycle read

endmodule

`default_nettype wire

/* verification/l2_cache_asserts.sv */
////////////////////////////////////////////////////////////
// line engine checks on memory bus protocol and fsm exits
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module l2_cache_asserts (
    input wire logic                   CLK,
    input wire logic                   nRST,
    input wire l2_cache_pkg::mem_req_t mem_req,
    input wire l2_cache_pkg::mem_rsp_t mem_rsp,
    input wire logic [1:0]             state,
    input wire logic                   miss
);

    localparam logic [1:0] IDLE = 2'd0;    // engine idle encoding

    // one direction per word
    a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else $error("memory ren and wen high together");

    // a stalled word keeps its address
    a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req.addr))
        else $error("memory address moved while memory busy was high");

    // only a miss starts a line transfer
    a_idle_exit: assert property (@(posedge CLK) disable iff (!nRST)
        (state == IDLE) && !miss |=> (state == IDLE))
        else $error("engine left idle with no miss");

endmodule

`default_nettype wire

/* verification/l2_cache_tb.sv */
////////////////////////////////////////////////////////////
// l2 cache testbench with memory model, shadow cache and step table
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "l2_cache_macros.svh"

module l2_cache_tb;

    import l2_cache_pkg::*;

    localparam int ACCESS_TIMEOUT = 64;    // cycles allowed per access

    typedef struct {
        string name;
        logic  is_write;
        word_t addr;
        word_t wdata;
    } step_t;

    logic      CLK;
    logic      nRST;
    proc_req_t proc_req;
    proc_rsp_t proc_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;

    integer    seed = 32'h6782;
    step_t     steps [$];
    word_t     mem_data [word_t];           // words written back to memory
    word_t     exp_mem [word_t];            // words the processor wrote
    word_t     wb_addr_q [$];
    word_t     wb_data_q [$];
    int        rd_words;
    int        checks;
    int        mismatches;
    int        other_errs;
    logic      timed_out;

    way_idx_t                sh_list  [`L2_SETS][`L2_ASSOC];   // [0] is the victim
    logic                    sh_valid [`L2_SETS][`L2_ASSOC];
    logic                    sh_dirty [`L2_SETS][`L2_ASSOC];
    logic [`L2_TAG_BITS-1:0] sh_tag   [`L2_SETS][`L2_ASSOC];

    l2_cache dut0 (
        .CLK(CLK), .nRST(nRST), .proc_req(proc_req), .proc_rsp(proc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    bind line_engine l2_cache_asserts asrt0 (
        .CLK(CLK), .nRST(nRST), .mem_req(mem_req), .mem_rsp(mem_rsp),
        .state(state), .miss(miss)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;              // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////
    function automatic word_t mem_init(input word_t addr);
        return addr ^ 32'hC0DE_0000;        // init content keyed by address
    endfunction

    initial begin
        logic  word_open;
        int    wait_left;
        word_t maddr;
        word_open    = 1'b0;
        wait_left    = 0;
        mem_rsp      = '0;
        mem_rsp.busy = 1'b1;
        forever begin
            @(negedge CLK);
            mem_rsp.busy = 1'b1;
            if (mem_req.ren || mem_req.wen) begin
                if (!word_open) begin
                    word_open = 1'b1;
                    wait_left = $unsigned($random(seed)) % 4;   // 0 to 3 stalls
                end else begin
                    wait_left = wait_left - 1;
                end
                if (wait_left == 0) begin
                    word_open    = 1'b0;
                    mem_rsp.busy = 1'b0;    // word done at next rising edge
                    maddr        = {mem_req.addr[31:2], 2'b00};
                    if (mem_req.wen) begin
                        mem_data[maddr] = mem_req.wdata;
                        wb_addr_q.push_back(mem_req.addr);
                        wb_data_q.push_back(mem_req.wdata);
                    end else begin
                        mem_rsp.rdata = mem_data.exists(maddr) ? mem_data[maddr]
                                                               : mem_init(maddr);
                        rd_words++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks and shadow model
    ////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_way(input string name, input way_idx_t exp, input way_idx_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected way %0d, actual way %0d", name, exp, act);
        end
    endtask

    function automatic word_t exp_word(input word_t addr);
        word_t a;
        a = {addr[31:2], 2'b00};
        if (exp_mem.exists(a)) begin
            return exp_mem[a];
        end
        return mem_init(a);
    endfunction

    function automatic word_t make_addr(input int tag, input int set_idx, input int blk);
        decoded_addr_t da;
        da.tag      = tag[`L2_TAG_BITS-1:0];
        da.set_idx  = set_idx[`L2_SET_BITS-1:0];
        da.block    = blk[`L2_BLOCK_BITS-1:0];
        da.byte_off = 2'b00;
        return da;
    endfunction

    task automatic touch_lru(input int s, input way_idx_t way);
        int p;
        p = 0;
        for (int k = 0; k < `L2_ASSOC; k++) begin
            if (sh_list[s][k] == way) begin
                p = k;
            end
        end
        for (int k = p; k < `L2_ASSOC - 1; k++) begin
            sh_list[s][k] = sh_list[s][k + 1];  // younger ones slide toward victim
        end
        sh_list[s][`L2_ASSOC-1] = way;
    endtask

    task automatic run_step(input step_t st);
        decoded_addr_t da;
        decoded_addr_t wa;
        way_idx_t      way;
        logic          was_hit;
        logic          exp_wb;
        logic          done;
        logic          found;
        word_t         got;
        word_t         line_base;
        int            cycles;
        da      = st.addr;
        was_hit = 1'b0;
        way     = sh_list[da.set_idx][0];  // victim unless a way hits
        for (int w = 0; w < `L2_ASSOC; w++) begin
            if (sh_valid[da.set_idx][w] && sh_tag[da.set_idx][w] == da.tag) begin
                was_hit = 1'b1;
                way     = way_idx_t'(w);
            end
        end
        exp_wb    = !was_hit && sh_valid[da.set_idx][way] && sh_dirty[da.set_idx][way];
        line_base = {sh_tag[da.set_idx][way], da.set_idx, 4'b0000};  // victim's old line
        @(negedge CLK);
        rd_words = 0;
        wb_addr_q.delete();
        wb_data_q.delete();
        proc_req.addr  = st.addr;
        proc_req.ren   = !st.is_write;
        proc_req.wen   = st.is_write;
        proc_req.wdata = st.wdata;
        done   = 1'b0;
        cycles = 0;
        got    = '0;
        while (!done && cycles < ACCESS_TIMEOUT) begin
            #2;                             // past the falling-edge drives
            if (!proc_rsp.busy) begin
                got  = proc_rsp.rdata;
                done = 1'b1;
            end else begin
                @(negedge CLK);
                cycles++;
            end
        end
        if (!done) begin
            timed_out = 1'b1;
            other_errs++;
            $display("timeout: %s still busy after %0d cycles", st.name, cycles);
        end else begin
            if (!st.is_write) begin
                check_word({st.name, " rdata"}, exp_word(st.addr), got);
            end
            if (was_hit) begin
                check_word({st.name, " hit cycles"}, '0, word_t'(cycles));
            end
            check_word({st.name, " mem reads"}, was_hit ? 0 : 4, word_t'(rd_words));
            check_word({st.name, " mem writes"}, exp_wb ? 4 : 0, word_t'(wb_addr_q.size()));
            for (int k = 0; k < wb_addr_q.size(); k++) begin
                check_word({st.name, " wb addr"}, line_base + word_t'(4 * k), wb_addr_q[k]);
                check_word({st.name, " wb data"}, exp_word(line_base + word_t'(4 * k)),
                           wb_data_q[k]);
            end
            if (wb_addr_q.size() != 0) begin
                wa    = wb_addr_q[0];
                found = 1'b0;
                for (int w = 0; w < `L2_ASSOC; w++) begin
                    if (sh_valid[wa.set_idx][w] && sh_tag[wa.set_idx][w] == wa.tag) begin
                        found = 1'b1;
                        check_way({st.name, " victim"}, way, way_idx_t'(w));
                    end
                end
                if (!found) begin
                    other_errs++;
                    $display("%s: write-back address %h is not a cached line", st.name, wa);
                end
            end
            if (!was_hit) begin
                sh_valid[da.set_idx][way] = 1'b1;
                sh_dirty[da.set_idx][way] = 1'b0;
                sh_tag[da.set_idx][way]   = da.tag;
            end
            if (st.is_write) begin
                sh_dirty[da.set_idx][way]       = 1'b1;
                exp_mem[{st.addr[31:2], 2'b00}] = st.wdata;
            end
            touch_lru(da.set_idx, way);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // step table
    ////////////////////////////////////////////////////////////
    task automatic add_step(input string name, input logic is_write, input word_t addr,
                            input word_t wdata);
        step_t st;
        st.name     = name;
        st.is_write = is_write;
        st.addr     = addr;
        st.wdata    = wdata;
        steps.push_back(st);
    endtask

    task automatic build_table();
        // set 1 gets a fill, a hit, a write hit and a read of the whole line
        add_step("rd_miss", 1'b0, make_addr('h21, 1, 2), '0);
        add_step("rd_hit", 1'b0, make_addr('h21, 1, 2), '0);
        add_step("wr_hit", 1'b1, make_addr('h21, 1, 1), 32'hA5A5_0001);
        for (int b = 0; b < `L2_BLOCK_WORDS; b++) begin
            add_step($sformatf("wr_hit_rd%0d", b), 1'b0, make_addr('h21, 1, b), '0);
        end
        // set 0 takes five dirty tags and the fifth pushes out the oldest
        for (int t = 0; t < 5; t++) begin
            add_step($sformatf("fill0_%0d", t), 1'b1, make_addr('h40 + t, 0, t % 4),
                     32'hD000_0000 + t);
        end
        add_step("rd_evicted", 1'b0, make_addr('h40, 0, 0), '0);
        // set 2 touches reorder the list before new misses
        for (int t = 0; t < 4; t++) begin
            add_step($sformatf("lru_fill%0d", t), 1'b1, make_addr('h80 + t, 2, 3),
                     32'hE000_0000 + t);
        end
        add_step("lru_touch2", 1'b0, make_addr('h82, 2, 3), '0);
        add_step("lru_touch0", 1'b0, make_addr('h80, 2, 0), '0);
        add_step("lru_new4", 1'b1, make_addr('h84, 2, 1), 32'hE000_0004);
        add_step("lru_new5", 1'b1, make_addr('h85, 2, 2), 32'hE000_0005);
        add_step("lru_old1", 1'b0, make_addr('h81, 2, 3), '0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        nRST       = 1'b0;
        proc_req   = '0;
        rd_words   = 0;
        checks     = 0;
        mismatches = 0;
        other_errs = 0;
        timed_out  = 1'b0;
        for (int s = 0; s < `L2_SETS; s++) begin
            for (int w = 0; w < `L2_ASSOC; w++) begin
                sh_list[s][w]  = way_idx_t'(w);   // identity list out of reset
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
            end
        end
        build_table();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        repeat (4) begin
            @(negedge CLK);
            #2;
            checks++;
            if (proc_rsp.busy || mem_req.ren || mem_req.wen) begin
                other_errs++;
                $display("busy or a memory strobe is high with no request after reset");
            end
        end
        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            run_step(steps[i]);
        end
        @(negedge CLK);
        proc_req = '0;
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
                 other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
